//--- Makefile
TOP := tb_spi_bridge

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

lint:
	verilator --lint-only -Wall --top-module spi_bridge_top \
		rtl/spi_bridge_pkg.sv rtl/spi_target.sv rtl/bus_cycle_master.sv \
		rtl/spi_command_regs.sv rtl/spi_bridge_top.sv

clean:
	rm -rf obj_dir

//--- project.f
rtl/spi_bridge_pkg.sv
rtl/spi_target.sv
rtl/bus_cycle_master.sv
rtl/spi_command_regs.sv
rtl/spi_bridge_top.sv
testbench/spi_bridge_properties.sv
testbench/tb_spi_bridge.sv

//--- rtl/bus_cycle_master.sv
`timescale 1ns/1ps
`default_nettype none

module bus_cycle_master (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 phi_fall,
    input  logic                                 phi_rise,
    input  logic                                 cycle_start,
    input  spi_bridge_pkg::cycle_kind_t          cycle_kind,
    input  logic                                 abort,
    input  logic [spi_bridge_pkg::data_width-1:0] rddata,
    output logic [spi_bridge_pkg::data_width-1:0] rd_result,
    output logic                                 rd_result_valid,
    output logic                                 rd_n,
    output logic                                 wr_n,
    output logic                                 mreq_n,
    output logic                                 iorq_n,
    output logic                                 wrdata_en
);

    import spi_bridge_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_cycle0,
        st_cycle1,
        st_cycle2,
        st_done
    } state_t;

    state_t      state;
    cycle_kind_t kind_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= st_idle;
            rd_n            <= 1'b1;
            wr_n            <= 1'b1;
            mreq_n          <= 1'b1;
            iorq_n          <= 1'b1;
            wrdata_en       <= 1'b0;
            rd_result_valid <= 1'b0;
        end else begin
            rd_result_valid <= 1'b0;
            if (abort) begin
                state     <= st_idle;  // new frame, drop whatever was running.
                rd_n      <= 1'b1;
                wr_n      <= 1'b1;
                mreq_n    <= 1'b1;
                iorq_n    <= 1'b1;
                wrdata_en <= 1'b0;
            end else begin
                case (state)
                    st_idle: begin
                        if (cycle_start)
                            state <= st_cycle0;
                    end
                    st_cycle0: begin
                        if (phi_fall) begin
                            mreq_n    <= kind_r.io;
                            iorq_n    <= !kind_r.io;
                            rd_n      <= !kind_r.read;
                            wrdata_en <= !kind_r.read;  // drive data for the whole write.
                            state     <= st_cycle1;
                        end
                    end
                    st_cycle1: begin
                        if (phi_fall) begin
                            wr_n  <= kind_r.read;
                            state <= st_cycle2;
                        end
                    end
                    st_cycle2: begin
                        if (phi_fall) begin
                            rd_result_valid <= kind_r.read;
                            rd_n            <= 1'b1;
                            wr_n            <= 1'b1;
                            mreq_n          <= 1'b1;
                            iorq_n          <= 1'b1;
                            state           <= st_done;
                        end
                    end
                    st_done: begin
                        if (phi_rise) begin
                            wrdata_en <= 1'b0;  // data hold past the strobes.
                            state     <= st_idle;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && cycle_start)
            kind_r <= cycle_kind;
        if (state == st_cycle2 && phi_fall && kind_r.read)
            rd_result <= rddata;  // sampled while rd_n is still low.
    end

endmodule

`default_nettype wire

//--- rtl/spi_bridge_pkg.sv
`default_nettype none

package spi_bridge_pkg;

    // command byte values, first byte of every frame.
    localparam logic [7:0] cmd_reset           = 8'h01;
    localparam logic [7:0] cmd_set_keyb_matrix = 8'h10;
    localparam logic [7:0] cmd_bus_acquire     = 8'h20;
    localparam logic [7:0] cmd_bus_release     = 8'h21;
    localparam logic [7:0] cmd_mem_write       = 8'h22;
    localparam logic [7:0] cmd_mem_read        = 8'h23;
    localparam logic [7:0] cmd_io_write        = 8'h24;
    localparam logic [7:0] cmd_io_read         = 8'h25;

    // computer bus geometry.
    localparam int addr_width = 16;
    localparam int data_width = 8;

    // keyboard matrix width used unless the top level overrides it.
    localparam int key_bits_default = 64;

    // kind of bus cycle handed to the sequencer.
    typedef struct packed {
        logic io;    // 1 selects iorq_n, 0 selects mreq_n.
        logic read;  // 1 for a read cycle, 0 for a write cycle.
    } cycle_kind_t;

endpackage

`default_nettype wire

//--- rtl/spi_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_bridge_top #(
    parameter int key_bits = spi_bridge_pkg::key_bits_default
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 esp_ssel_n,
    input  logic                                 esp_sclk,
    input  logic                                 esp_mosi,
    output logic                                 esp_miso,
    input  logic                                 ebus_phi,
    output logic [spi_bridge_pkg::addr_width-1:0] bus_a,
    input  logic [spi_bridge_pkg::data_width-1:0] bus_rddata,
    output logic [spi_bridge_pkg::data_width-1:0] bus_wrdata,
    output logic                                 bus_wrdata_en,
    output logic                                 bus_rd_n,
    output logic                                 bus_wr_n,
    output logic                                 bus_mreq_n,
    output logic                                 bus_iorq_n,
    output logic                                 bus_busreq,
    output logic                                 reset_req,
    output logic [key_bits-1:0]                  keys
);

    // host spi pins on one side, computer bus on the other.
    spi_command_regs #(
        .key_bits (key_bits)
    ) u_spi_command_regs (
        .clk       (clk),
        .reset     (reset),
        .ssel_n    (esp_ssel_n),
        .sclk      (esp_sclk),
        .mosi      (esp_mosi),
        .miso      (esp_miso),
        .phi       (ebus_phi),
        .a         (bus_a),
        .rddata    (bus_rddata),
        .wrdata    (bus_wrdata),
        .wrdata_en (bus_wrdata_en),
        .rd_n      (bus_rd_n),
        .wr_n      (bus_wr_n),
        .mreq_n    (bus_mreq_n),
        .iorq_n    (bus_iorq_n),
        .busreq    (bus_busreq),
        .reset_req (reset_req),
        .keys      (keys)
    );

endmodule

`default_nettype wire

//--- rtl/spi_command_regs.sv
`timescale 1ns/1ps
`default_nettype none

module spi_command_regs #(
    parameter int key_bits = spi_bridge_pkg::key_bits_default
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 ssel_n,
    input  logic                                 sclk,
    input  logic                                 mosi,
    output logic                                 miso,
    input  logic                                 phi,
    output logic [spi_bridge_pkg::addr_width-1:0] a,
    input  logic [spi_bridge_pkg::data_width-1:0] rddata,
    output logic [spi_bridge_pkg::data_width-1:0] wrdata,
    output logic                                 wrdata_en,
    output logic                                 rd_n,
    output logic                                 wr_n,
    output logic                                 mreq_n,
    output logic                                 iorq_n,
    output logic                                 busreq,
    output logic                                 reset_req,
    output logic [key_bits-1:0]                  keys
);

    import spi_bridge_pkg::*;

    logic                  msg_start;
    logic                  msg_end;
    logic [7:0]            rxdata;
    logic                  rxdata_valid;
    logic [data_width-1:0] txdata;
    logic                  txdata_ack;
    logic                  tx_pending;
    logic                  in_frame;
    logic [7:0]            cmd;
    logic [2:0]            byte_cnt;
    logic [key_bits-1:0]   key_sr;
    logic [2:0]            phi_q;
    logic                  phi_fall;
    logic                  phi_rise;
    logic                  cmd_is_read;
    logic                  cmd_is_write;
    cycle_kind_t           cycle_kind;
    logic                  cycle_start;
    logic [data_width-1:0] rd_result;
    logic                  rd_result_valid;

    spi_target u_spi_target (
        .clk          (clk),
        .reset        (reset),
        .ssel_n       (ssel_n),
        .sclk         (sclk),
        .mosi         (mosi),
        .miso         (miso),
        .msg_start    (msg_start),
        .msg_end      (msg_end),
        .rxdata       (rxdata),
        .rxdata_valid (rxdata_valid),
        .txdata       (txdata),
        .txdata_ack   (txdata_ack)
    );

    bus_cycle_master u_bus_cycle_master (
        .clk             (clk),
        .reset           (reset),
        .phi_fall        (phi_fall),
        .phi_rise        (phi_rise),
        .cycle_start     (cycle_start),
        .cycle_kind      (cycle_kind),
        .abort           (msg_start),
        .rddata          (rddata),
        .rd_result       (rd_result),
        .rd_result_valid (rd_result_valid),
        .rd_n            (rd_n),
        .wr_n            (wr_n),
        .mreq_n          (mreq_n),
        .iorq_n          (iorq_n),
        .wrdata_en       (wrdata_en)
    );

    assign cmd_is_read     = (cmd == cmd_mem_read) || (cmd == cmd_io_read);
    assign cmd_is_write    = (cmd == cmd_mem_write) || (cmd == cmd_io_write);
    assign cycle_kind.io   = (cmd == cmd_io_read) || (cmd == cmd_io_write);
    assign cycle_kind.read = cmd_is_read;

    // phi comes from the computer clock domain.
    assign phi_fall = phi_q[2] && !phi_q[1];
    assign phi_rise = !phi_q[2] && phi_q[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            phi_q       <= 3'b000;
            in_frame    <= 1'b0;
            cmd         <= 8'h00;
            byte_cnt    <= 3'd0;
            cycle_start <= 1'b0;
            reset_req   <= 1'b0;
            busreq      <= 1'b0;
            keys        <= '0;
        end else begin
            phi_q       <= {phi_q[1:0], phi};
            reset_req   <= msg_end && (cmd == cmd_reset);
            cycle_start <= rxdata_valid && in_frame &&
                           ((byte_cnt == 3'd2 && cmd_is_read) ||
                            (byte_cnt == 3'd3 && cmd_is_write));
            if (msg_start) begin
                in_frame <= 1'b1;
                cmd      <= 8'h00;  // no command until the first byte.
                byte_cnt <= 3'd0;
            end else if (msg_end) begin
                in_frame <= 1'b0;
            end else if (rxdata_valid && in_frame) begin
                if (byte_cnt == 3'd0)
                    cmd <= rxdata;
                if (byte_cnt != 3'd7)
                    byte_cnt <= byte_cnt + 3'd1;  // saturates past the data byte.
            end
            if (msg_end && cmd == cmd_set_keyb_matrix)
                keys <= key_sr;
            if (phi_fall && cmd == cmd_bus_acquire)
                busreq <= 1'b1;
            if (phi_fall && cmd == cmd_bus_release)
                busreq <= 1'b0;
        end
    end

    // argument bytes, address low then high, then write data.
    always_ff @(posedge clk) begin
        if (rxdata_valid && in_frame && byte_cnt != 3'd0) begin
            key_sr <= {rxdata, key_sr[key_bits-1:8]};  // first byte lands lowest.
            if (byte_cnt == 3'd1)
                a[7:0] <= rxdata;
            if (byte_cnt == 3'd2)
                a[15:8] <= rxdata;
            if (byte_cnt == 3'd3)
                wrdata <= rxdata;
        end
    end

    // read data is returned once, on the next byte the host clocks.
    always_ff @(posedge clk) begin
        if (reset) begin
            txdata     <= '0;
            tx_pending <= 1'b0;
        end else if (msg_start) begin
            txdata     <= '0;
            tx_pending <= 1'b0;
        end else if (rd_result_valid) begin
            txdata     <= rd_result;
            tx_pending <= 1'b1;
        end else if (txdata_ack && tx_pending) begin
            txdata     <= '0;
            tx_pending <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/spi_target.sv
`timescale 1ns/1ps
`default_nettype none

module spi_target (
    input  logic       clk,
    input  logic       reset,
    input  logic       ssel_n,
    input  logic       sclk,
    input  logic       mosi,
    output logic       miso,
    output logic       msg_start,
    output logic       msg_end,
    output logic [7:0] rxdata,
    output logic       rxdata_valid,
    input  logic [7:0] txdata,
    output logic       txdata_ack
);

    logic [2:0] ssel_q;
    logic [2:0] sclk_q;
    logic [1:0] mosi_q;
    logic       selected;
    logic       sclk_rise;
    logic       sclk_fall;
    logic [2:0] bit_cnt;
    logic [6:0] rx_shift;
    logic [7:0] tx_shift;
    logic       tx_armed;

    always_ff @(posedge clk) begin
        if (reset) begin
            ssel_q <= 3'b111;  // deselected.
            sclk_q <= 3'b000;
            mosi_q <= 2'b00;
        end else begin
            ssel_q <= {ssel_q[1:0], ssel_n};
            sclk_q <= {sclk_q[1:0], sclk};
            mosi_q <= {mosi_q[0], mosi};
        end
    end

    assign selected  = !ssel_q[1];
    assign sclk_rise = selected && sclk_q[1] && !sclk_q[2];
    assign sclk_fall = selected && !sclk_q[1] && sclk_q[2];

    always_ff @(posedge clk) begin
        if (reset) begin
            msg_start    <= 1'b0;
            msg_end      <= 1'b0;
            bit_cnt      <= 3'd0;
            rxdata_valid <= 1'b0;
        end else begin
            msg_start    <= ssel_q[2] && !ssel_q[1];
            msg_end      <= !ssel_q[2] && ssel_q[1];
            rxdata_valid <= 1'b0;
            if (!selected) begin
                bit_cnt <= 3'd0;
            end else if (sclk_rise) begin
                bit_cnt      <= bit_cnt + 3'd1;
                rxdata_valid <= (bit_cnt == 3'd7);  // eighth bit completes the byte.
            end
        end
    end

    // receive shifter, msb first.
    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            rx_shift <= {rx_shift[5:0], mosi_q[1]};
            if (bit_cnt == 3'd7)
                rxdata <= {rx_shift, mosi_q[1]};
        end
    end

    // while armed the shifter follows txdata so the msb is ready before the first rise.
    always_ff @(posedge clk) begin
        if (reset) begin
            tx_armed   <= 1'b0;
            txdata_ack <= 1'b0;
            tx_shift   <= 8'h00;
        end else begin
            txdata_ack <= 1'b0;
            if (!selected) begin
                tx_armed <= 1'b1;
            end else if (sclk_rise && bit_cnt == 3'd0) begin
                tx_armed   <= 1'b0;  // byte started, txdata is taken.
                txdata_ack <= 1'b1;
            end else if (sclk_fall && bit_cnt == 3'd0) begin
                tx_armed <= 1'b1;
            end

            if (tx_armed)
                tx_shift <= txdata;
            else if (sclk_fall)
                tx_shift <= (bit_cnt == 3'd0) ? txdata : {tx_shift[6:0], 1'b0};
        end
    end

    assign miso = tx_shift[7];

endmodule

`default_nettype wire

//--- testbench/spi_bridge_properties.sv
`timescale 1ns/1ps
`default_nettype none

module spi_bridge_properties (
    input logic clk,
    input logic reset,
    input logic rd_n,
    input logic wr_n,
    input logic mreq_n,
    input logic iorq_n,
    input logic wrdata_en,
    input logic reset_req
);

    a_one_space: assert property (@(posedge clk) disable iff (reset) mreq_n || iorq_n)
        else $error("mreq_n and iorq_n are low together");

    a_one_direction: assert property (@(posedge clk) disable iff (reset) rd_n || wr_n)
        else $error("rd_n and wr_n are low together");

    // write data must be on the bus for the whole wr_n pulse.
    a_write_data_driven: assert property (@(posedge clk) disable iff (reset)
        !wr_n |-> wrdata_en)
        else $error("wr_n is low while wrdata_en is 0");

    a_reset_req_single: assert property (@(posedge clk) disable iff (reset)
        reset_req |=> !reset_req)
        else $error("reset_req stayed high for two clk");

endmodule

bind spi_command_regs spi_bridge_properties i_properties (
    .clk       (clk),
    .reset     (reset),
    .rd_n      (rd_n),
    .wr_n      (wr_n),
    .mreq_n    (mreq_n),
    .iorq_n    (iorq_n),
    .wrdata_en (wrdata_en),
    .reset_req (reset_req)
);

`default_nettype wire

//--- testbench/tb_spi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_bridge;

    import spi_bridge_pkg::*;

    typedef struct packed {
        logic [7:0]  cmd;
        logic [15:0] addr;
        logic [7:0]  data;      // write data when not random.
        logic [7:0]  expected;  // reset pulse count or busreq level.
        logic        rnd;       // data comes from the lfsr.
    } row_t;

    localparam int num_rows       = 11;
    localparam int key_bits       = 64;
    localparam int timeout_cycles = num_rows * 20 * 100;

    logic                clk = 1'b0;
    logic                reset;
    logic                esp_ssel_n;
    logic                esp_sclk;
    logic                esp_mosi;
    logic                esp_miso;
    logic                ebus_phi = 1'b0;
    logic [1:0]          phi_div = 2'd0;
    logic [15:0]         bus_a;
    logic [7:0]          bus_rddata;
    logic [7:0]          bus_wrdata;
    logic                bus_wrdata_en;
    logic                bus_rd_n;
    logic                bus_wr_n;
    logic                bus_mreq_n;
    logic                bus_iorq_n;
    logic                bus_busreq;
    logic                reset_req;
    logic [key_bits-1:0] keys;

    logic [7:0]  mem_model [256];
    logic [7:0]  io_model [256];
    logic [7:0]  mem_exp [256];  // what each model should hold.
    logic [7:0]  io_exp [256];
    row_t        rows [num_rows];
    logic [23:0] lfsr_state;
    logic [15:0] cycle_addr;     // bus_a when the last cycle opened.
    int          cycle_cnt = 0;
    int          errors = 0;
    int          tests_failed = 0;
    int          reset_pulses = 0;
    int          cycles_started = 0;
    int          writes_ended = 0;

    spi_bridge_top #(
        .key_bits (key_bits)
    ) i_dut (
        .clk           (clk),
        .reset         (reset),
        .esp_ssel_n    (esp_ssel_n),
        .esp_sclk      (esp_sclk),
        .esp_mosi      (esp_mosi),
        .esp_miso      (esp_miso),
        .ebus_phi      (ebus_phi),
        .bus_a         (bus_a),
        .bus_rddata    (bus_rddata),
        .bus_wrdata    (bus_wrdata),
        .bus_wrdata_en (bus_wrdata_en),
        .bus_rd_n      (bus_rd_n),
        .bus_wr_n      (bus_wr_n),
        .bus_mreq_n    (bus_mreq_n),
        .bus_iorq_n    (bus_iorq_n),
        .bus_busreq    (bus_busreq),
        .reset_req     (reset_req),
        .keys          (keys)
    );

    always #5 clk = ~clk;

    // phi period is 8 clk.
    always @(posedge clk) begin
        phi_div <= phi_div + 2'd1;
        if (phi_div == 2'd3)
            ebus_phi <= !ebus_phi;
    end

    function automatic logic [7:0] mem_fill(input logic [7:0] addr);
        return addr ^ 8'h5a;
    endfunction

    function automatic logic [7:0] io_fill(input logic [7:0] addr);
        return {addr[3:0], addr[7:4]} ^ 8'hc3;
    endfunction

    // x^24 + x^23 + x^22 + x^17 + 1, one step per bit.
    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        logic       fb;
        b = 8'h00;
        for (int i = 0; i < 8; i++) begin
            fb         = lfsr_state[23] ^ lfsr_state[22] ^ lfsr_state[21] ^ lfsr_state[16];
            lfsr_state = {lfsr_state[22:0], fb};
            b          = {b[6:0], fb};
        end
        return b;
    endfunction

    // bus models, indexed by the low address byte.
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem_model[i] = mem_fill(8'(i));
            io_model[i]  = io_fill(8'(i));
        end
        forever begin
            @(negedge bus_wr_n);
            if (!bus_mreq_n)
                mem_model[bus_a[7:0]] = bus_wrdata;
            if (!bus_iorq_n)
                io_model[bus_a[7:0]] = bus_wrdata;
        end
    end

    assign bus_rddata = (!bus_rd_n && !bus_mreq_n) ? mem_model[bus_a[7:0]] :
                        (!bus_rd_n && !bus_iorq_n) ? io_model[bus_a[7:0]] : 8'hff;

    // a cycle opens when its space strobe falls.
    always @(negedge bus_mreq_n or negedge bus_iorq_n) begin
        cycle_addr     = bus_a;
        cycles_started = cycles_started + 1;
    end

    always @(negedge bus_wrdata_en)
        writes_ended = writes_ended + 1;  // data released, write is over.

    always @(negedge clk) begin
        if (reset_req)
            reset_pulses <= reset_pulses + 1;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == timeout_cycles) begin
            $display("timeout after %0d clk cycles, the transaction table did not finish",
                     timeout_cycles);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("ERR %s got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk);
        @(negedge clk);  // sample away from the active edge.
    endtask

    task automatic wait_write_end(input int ended_before);
        int n;
        n = 0;
        while (writes_ended == ended_before && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (writes_ended == ended_before) begin
            $display("write cycle did not end within 100 clk after the frame");
            errors++;
        end
    endtask

    // mode 0, msb first, about 6 clk per half period.
    task automatic spi_transfer(input logic [7:0] tx, output logic [7:0] rx);
        rx = 8'h00;
        for (int i = 7; i >= 0; i--) begin
            @(posedge clk);
            esp_mosi <= tx[i];
            repeat (5) @(posedge clk);
            @(negedge clk);
            rx = {rx[6:0], esp_miso};  // taken just before the rising edge.
            @(posedge clk);
            esp_sclk <= 1'b1;
            repeat (6) @(posedge clk);
            esp_sclk <= 1'b0;
        end
    endtask

    task automatic send_expect_zero(input logic [7:0] tx);
        logic [7:0] rx;
        spi_transfer(tx, rx);
        check_value("miso", 64'(rx), 64'h0);
    endtask

    task automatic select_target();
        @(posedge clk);
        esp_ssel_n <= 1'b0;
        repeat (6) @(posedge clk);
    endtask

    task automatic release_target();
        repeat (6) @(posedge clk);
        esp_ssel_n <= 1'b1;
        repeat (12) @(posedge clk);
    endtask

    task automatic check_models(input logic [7:0] lo);
        check_value("mem_model", 64'(mem_model[lo]), 64'(mem_exp[lo]));
        check_value("io_model", 64'(io_model[lo]), 64'(io_exp[lo]));
    endtask

    // one bus cycle per frame, on the full 16-bit address.
    task automatic check_bus_cycle(input int started_before, input logic [15:0] addr);
        check_value("bus cycles", 64'(cycles_started - started_before), 64'h1);
        check_value("bus_a", 64'(cycle_addr), 64'(addr));
    endtask

    task automatic run_row(input int idx);
        row_t        r;
        logic [7:0]  data;
        logic [7:0]  rx;
        logic [7:0]  lo;
        logic [63:0] key_exp;
        int          pulses_before;
        int          errors_before;
        int          started_before;
        int          ended_before;
        r             = rows[idx];
        lo            = r.addr[7:0];
        errors_before = errors;
        key_exp       = 64'h0;
        case (r.cmd)
            cmd_set_keyb_matrix: begin
                select_target();
                send_expect_zero(r.cmd);
                for (int k = 0; k < 8; k++) begin
                    data                = r.rnd ? random_byte() : r.data;
                    key_exp[8*k +: 8]   = data;  // first byte in the lowest bits.
                    send_expect_zero(data);
                end
                release_target();
                wait_clocks(2);
                check_value("keys", keys, key_exp);
            end
            cmd_reset: begin
                pulses_before = reset_pulses;
                select_target();
                send_expect_zero(r.cmd);
                release_target();
                wait_clocks(20);
                check_value("reset_req pulses", 64'(reset_pulses - pulses_before),
                            64'(r.expected));
            end
            cmd_bus_acquire, cmd_bus_release: begin
                select_target();
                send_expect_zero(r.cmd);
                release_target();
                wait_clocks(16);  // two phi periods.
                check_value("busreq", 64'(bus_busreq), 64'(r.expected));
            end
            cmd_mem_write, cmd_io_write: begin
                data           = r.rnd ? random_byte() : r.data;
                started_before = cycles_started;
                ended_before   = writes_ended;
                select_target();
                send_expect_zero(r.cmd);
                send_expect_zero(r.addr[7:0]);
                send_expect_zero(r.addr[15:8]);
                send_expect_zero(data);
                release_target();
                wait_write_end(ended_before);
                if (r.cmd == cmd_mem_write)
                    mem_exp[lo] = data;
                else
                    io_exp[lo] = data;
                check_bus_cycle(started_before, r.addr);
                check_models(lo);
            end
            cmd_mem_read, cmd_io_read: begin
                started_before = cycles_started;
                select_target();
                send_expect_zero(r.cmd);
                send_expect_zero(r.addr[7:0]);
                send_expect_zero(r.addr[15:8]);
                repeat (32) @(posedge clk);  // four phi periods, select held low.
                spi_transfer(8'h00, rx);
                release_target();
                wait_clocks(2);
                if (r.cmd == cmd_mem_read)
                    check_value("miso", 64'(rx), 64'(mem_exp[lo]));
                else
                    check_value("miso", 64'(rx), 64'(io_exp[lo]));
                check_bus_cycle(started_before, r.addr);
                check_models(lo);
            end
            default: begin
                $display("row %0d holds a command the table runner does not know", idx);
                errors++;
            end
        endcase
        check_value("strobes rd_n wr_n mreq_n iorq_n",
                    64'({bus_rd_n, bus_wr_n, bus_mreq_n, bus_iorq_n}), 64'hf);
        check_value("wrdata_en", 64'(bus_wrdata_en), 64'h0);
        if (errors != errors_before)
            tests_failed++;
        $display("test %0d cmd %h addr %h: %s", idx + 1, r.cmd, r.addr,
                 (errors == errors_before) ? "pass" : "FAIL");
    endtask

    initial begin
        int errors_before;
        reset      = 1'b1;
        esp_ssel_n = 1'b1;
        esp_sclk   = 1'b0;
        esp_mosi   = 1'b0;
        lfsr_state = 24'd84038;
        for (int i = 0; i < 256; i++) begin
            mem_exp[i] = mem_fill(8'(i));
            io_exp[i]  = io_fill(8'(i));
        end
        rows = '{
            '{cmd_set_keyb_matrix, 16'h0000, 8'h00, 8'h00, 1'b1},
            '{cmd_reset,           16'h0000, 8'h00, 8'h01, 1'b0},
            '{cmd_bus_acquire,     16'h0000, 8'h00, 8'h01, 1'b0},
            '{cmd_mem_write,       16'h1234, 8'h00, 8'h00, 1'b1},
            '{cmd_mem_read,        16'h1234, 8'h00, 8'h00, 1'b0},
            '{cmd_io_write,        16'h0042, 8'ha5, 8'h00, 1'b0},
            '{cmd_io_read,         16'h0042, 8'h00, 8'h00, 1'b0},
            '{cmd_io_write,        16'h8034, 8'h00, 8'h00, 1'b1},  // same low byte as 1234.
            '{cmd_io_read,         16'h8034, 8'h00, 8'h00, 1'b0},
            '{cmd_mem_read,        16'h5577, 8'h00, 8'h00, 1'b0},  // never written.
            '{cmd_bus_release,     16'h0000, 8'h00, 8'h00, 1'b0}
        };
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        errors_before = errors;
        check_value("strobes rd_n wr_n mreq_n iorq_n",
                    64'({bus_rd_n, bus_wr_n, bus_mreq_n, bus_iorq_n}), 64'hf);
        check_value("busreq", 64'(bus_busreq), 64'h0);
        check_value("reset_req", 64'(reset_req), 64'h0);
        check_value("wrdata_en", 64'(bus_wrdata_en), 64'h0);
        check_value("keys", keys, 64'h0);
        if (errors != errors_before)
            tests_failed++;
        $display("test 0 after reset: %s", (errors == errors_before) ? "pass" : "FAIL");
        for (int i = 0; i < num_rows; i++)
            run_row(i);
        $display("%0d tests run, %0d failed, %0d check errors", num_rows + 1, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
